/* all.f */
+incdir+rtl
rtl/ck_ctrl_pkg.sv
rtl/ck_types_pkg.sv
rtl/ck_sbox.sv
rtl/ck_round_decode.sv
rtl/ck_round_execute.sv
rtl/ck_round_result.sv
rtl/ck_engine_top.sv
bench/ck_engine_props.sv
bench/ck_engine_tb.sv

/* bench/ck_engine_props.sv */
`default_nettype none

module ck_engine_props (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   cmd_valid,
	input logic                   out_valid,
	input ck_types_pkg::ck_key_t  out_key,
	input ck_types_pkg::ck_word_t even_key,
	input ck_types_pkg::ck_word_t odd_key
);
	timeunit 1ns;
	timeprecision 100ps;
	import ck_ctrl_pkg::*;

	a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid high right after a reset cycle");

	// two register stages between strobe and result.
	a_result_has_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(cmd_valid, 2))
		else $error("out_valid without a strobe two cycles before");

	a_odd_kept: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && out_key.slot == SLOT_EVEN) |-> $stable(odd_key))
		else $error("odd slot changed on an even write");

	a_even_kept: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && out_key.slot == SLOT_ODD) |-> $stable(even_key))
		else $error("even slot changed on an odd write");

	a_slots_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> ($stable(even_key) && $stable(odd_key)))
		else $error("a slot changed with no result");

endmodule

bind ck_engine_top ck_engine_props u_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.cmd_valid(cmd_valid),
	.out_valid(out_valid),
	.out_key  (out_key),
	.even_key (even_key),
	.odd_key  (odd_key)
);

`default_nettype wire

/* bench/ck_engine_tb.sv */
`include "ck_defines.svh"
`default_nettype none

module ck_engine_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import ck_types_pkg::*;
	import ck_ctrl_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 8;
	localparam int N_SEED       = 50;
	localparam int N_CHAIN      = 50;  // per chain phase.
	localparam int N_MIX        = 2000;
	localparam int MAX_GAP      = 3;
	localparam int TOTAL_CMDS   = 1 + N_SEED + 2 * N_CHAIN + N_MIX;
	localparam int LIMIT_CYCLES = TOTAL_CMDS * (MAX_GAP + 1) + RESET_CYCLES + 20;

	// model copy of the substitution table with entry 0 in the low byte.
	localparam logic [2047:0] ref_table = {
		128'h22cce3bd368ade651ad93f10200b80bf,
		128'h21045432a93d9038cd1c66ad8572d8c1,
		128'hc71d9a295b4e5d7d8ddcb8f3508bf49e,
		128'h628e23fd30067e9969f85e46d4a3e0ce,
		128'hc3f50efecb2aacb08fbcebca880aa2ab,
		128'heed5ef915c9cf9afb22f61ff352dc886,
		128'h4d53bb00baa0b492ed9b977fe84a636d,
		128'he2dadff2a598b3d240c63aa770f779f6,
		128'h483c0f71688295d676091803ae316733,
		128'h7cdd4593f0d36a5857c452e573f1cf94,
		128'hd1a67841830d51db5fc9147bd00c77b9,
		128'hea1219c25517e6649f1eb1fa1bd7e459,
		128'h493728aa11c560b66c75022c4347ecbe,
		128'hfc016f1f08a405a84426e10784b56e8c,
		128'h2b2542876b7a899d4b7416a13e2413fb,
		128'he7812ec03b4f4c155627965ab734e939
	};

	logic     clk;
	logic     rst_n;
	logic     cmd_valid;
	ck_cmd_t  cmd;
	logic     out_valid;
	ck_key_t  out_key;
	ck_word_t even_key;
	ck_word_t odd_key;

	logic [31:0] lfsr = 32'd68574;
	int          neg_count = 0;
	ck_word_t    model_chain = '0;
	ck_word_t    model_even = '0;
	ck_word_t    model_odd = '0;
	ck_key_t     last_key = '0;
	ck_key_t     seen_key;
	int          seen_due;
	ck_key_t     exp_q[$];
	int          due_q[$];

	ck_engine_top u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.out_valid(out_valid),
		.out_key  (out_key),
		.even_key (even_key),
		.odd_key  (odd_key)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_key(input string name, input ck_key_t got, input ck_key_t exp);
		if (got !== exp)
			abort_run($sformatf("Error %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_word(input string name, input ck_word_t got, input ck_word_t exp);
		if (got !== exp)
			abort_run($sformatf("Error %s: got %h, expected %h", name, got, exp));
	endtask

	// taps 32, 22, 2, 1; one step per bit.
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[62:0], fb};
		end
		return v;
	endfunction

	function automatic ck_byte_t table_entry(input ck_byte_t i);
		return ref_table[int'(i) * 8 +: 8];
	endfunction

	function automatic ck_cmd_t random_cmd();
		ck_cmd_t c;
		c.init  = (rand_bits(3) == 64'd0); // about one in eight.
		c.block = ck_block_t'(rand_bits(32));
		c.seed  = ck_seed_t'(rand_bits(48));
		c.loops = ck_loop_t'(rand_bits(32));
		return c;
	endfunction

	function automatic ck_key_t expected_key(input ck_cmd_t c, input ck_word_t prev);
		ck_key_t  k;
		ck_seed_t opnd;
		ck_byte_t b [6];
		ck_byte_t v [6];
		ck_byte_t s;
		ck_byte_t lo_sum;
		ck_byte_t hi_sum;
		if (c.init || c.block[`CK_MODE_BITS] == `CK_MODE_SEED)
			opnd = c.seed;
		else
			opnd = prev[47:0];
		for (int i = 0; i < 6; i++)
			b[i] = opnd[i * 8 +: 8];
		s = b[5];
		if (c.init) begin
			lo_sum = b[0] + b[1] + b[2];
			hi_sum = b[3] + b[4];
			k.word = {hi_sum, 8'h00, b[4], b[3], lo_sum, b[2], b[1], b[0]};
		end else begin
			for (int i = 0; i < 6; i++)
				v[i] = table_entry(b[i] + s) ^ b[i];
			v[0] = v[0] ^ c.loops[7:0];
			v[1] = v[1] ^ c.loops[15:8];
			lo_sum = v[0] + v[1] + v[2];
			hi_sum = v[3] + v[4] + v[5];
			k.word = {hi_sum, v[5], v[4], v[3], lo_sum, v[2], v[1], v[0]};
		end
		k.valid = 1'b1;
		k.slot  = c.block[`CK_SLOT_BIT] ? SLOT_ODD : SLOT_EVEN;
		return k;
	endfunction

	// called on a rising edge; leaves on a rising edge.
	task automatic issue(input ck_cmd_t c, input int gap);
		ck_key_t k;
		k = expected_key(c, model_chain);
		model_chain = k.word;
		exp_q.push_back(k);
		due_q.push_back(neg_count + 3);
		cmd_valid <= 1'b1;
		cmd       <= c;
		@(posedge clk);
		if (gap > 0) begin
			cmd_valid <= 1'b0;
			repeat (gap) @(posedge clk);
		end
	endtask

	// outputs settle after the rising edge so they are sampled on the falling one.
	always @(negedge clk) begin
		neg_count = neg_count + 1;
		if (rst_n) begin
			if (out_valid) begin
				if (exp_q.size() == 0)
					abort_run("out_valid pulsed with no command outstanding");
				seen_key = exp_q.pop_front();
				seen_due = due_q.pop_front();
				if (seen_due != neg_count)
					abort_run($sformatf("result came at cycle %0d instead of cycle %0d",
						neg_count, seen_due));
				last_key = seen_key;
				if (seen_key.slot == SLOT_ODD)
					model_odd = seen_key.word;
				else
					model_even = seen_key.word;
			end
			check_key("out_key", out_key, last_key);
			check_word("even_key", even_key, model_even);
			check_word("odd_key", odd_key, model_odd);
		end
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before all results came back");
	end

	initial begin
		ck_cmd_t c;
		rst_n     <= 1'b0;
		cmd_valid <= 1'b0;
		cmd       <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk); // slots must stay zero while idle.

		c = random_cmd();
		c.init = 1'b1;
		issue(c, 3);

		for (int i = 0; i < N_SEED; i++) begin
			c = random_cmd();
			c.init = 1'b0;
			c.block[`CK_MODE_BITS] = `CK_MODE_SEED;
			issue(c, int'(rand_bits(1)));
		end

		// chain runs back to back and then with gaps.
		for (int i = 0; i < 2 * N_CHAIN; i++) begin
			c = random_cmd();
			c.init = 1'b0;
			if (c.block[`CK_MODE_BITS] == `CK_MODE_SEED)
				c.block[`CK_MODE_BITS] = 2'b00;
			issue(c, (i < N_CHAIN) ? 0 : int'(rand_bits(2)));
		end

		for (int i = 0; i < N_MIX; i++) begin
			c = random_cmd();
			issue(c, int'(rand_bits(2)));
		end
		cmd_valid <= 1'b0;

		for (int i = 0; i < 10 && exp_q.size() != 0; i++)
			@(posedge clk);
		@(posedge clk);
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d results still missing at the end", exp_q.size()));
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* rtl/ck_ctrl_pkg.sv */
`default_nettype none

package ck_ctrl_pkg;

	// where the round operand comes from.
	typedef enum logic {
		SRC_SEED  = 1'b0,
		SRC_CHAIN = 1'b1
	} ck_src_e;

	// which key slot a result lands in.
	typedef enum logic {
		SLOT_EVEN = 1'b0,
		SLOT_ODD  = 1'b1
	} ck_slot_e;

endpackage

`default_nettype wire

/* rtl/ck_defines.svh */
`ifndef CK_DEFINES_SVH
`define CK_DEFINES_SVH

// bytes in one key word.
`define CK_BYTES 8

// seed operand width in bytes.
// its top byte is the seed added before each lookup.
`define CK_SEED_BYTE 6

// loop value width. only bytes 0 and 1 mix into the key.
`define CK_LOOP_W 32

// block header fields.
`define CK_MODE_BITS 31:30
`define CK_SLOT_BIT 29

// mode that selects the fresh seed word.
`define CK_MODE_SEED 2'b01

`endif

/* rtl/ck_engine_top.sv */
`default_nettype none

module ck_engine_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cmd_valid,
	input  ck_types_pkg::ck_cmd_t  cmd,
	output logic                   out_valid,
	output ck_types_pkg::ck_key_t  out_key,
	output ck_types_pkg::ck_word_t even_key,
	output ck_types_pkg::ck_word_t odd_key
);
	import ck_types_pkg::*;

	ck_op_t   op;
	ck_key_t  key;
	ck_word_t chain;

	ck_round_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.op       (op)
	);

	// combinational stage between the two register stages.
	ck_round_execute u_execute (
		.op   (op),
		.chain(chain),
		.key  (key)
	);

	ck_round_result u_result (
		.clk      (clk),
		.rst_n    (rst_n),
		.key      (key),
		.chain    (chain),
		.out_valid(out_valid),
		.out_key  (out_key),
		.even_key (even_key),
		.odd_key  (odd_key)
	);

endmodule

`default_nettype wire

/* rtl/ck_round_decode.sv */
`include "ck_defines.svh"
`default_nettype none

module ck_round_decode (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cmd_valid,
	input  ck_types_pkg::ck_cmd_t cmd,
	output ck_types_pkg::ck_op_t  op
);
	import ck_ctrl_pkg::*;

	ck_src_e  src_d;
	ck_slot_e slot_d;

	// any mode but seed runs on the chain word.
	assign src_d = (cmd.block[`CK_MODE_BITS] == `CK_MODE_SEED) ? SRC_SEED : SRC_CHAIN;
	assign slot_d = cmd.block[`CK_SLOT_BIT] ? SLOT_ODD : SLOT_EVEN;

	// valid qualifies the payload.
	always_ff @(posedge clk) begin
		op.init  <= cmd.init;
		op.src   <= src_d;
		op.slot  <= slot_d;
		op.seed  <= cmd.seed;
		op.loops <= cmd.loops;
		if (!rst_n)
			op.valid <= 1'b0;
		else
			op.valid <= cmd_valid;
	end

endmodule

`default_nettype wire

/* rtl/ck_round_execute.sv */
`include "ck_defines.svh"
`default_nettype none

module ck_round_execute (
	input  ck_types_pkg::ck_op_t   op,
	input  ck_types_pkg::ck_word_t chain,
	output ck_types_pkg::ck_key_t  key
);
	import ck_types_pkg::*;
	import ck_ctrl_pkg::*;

	ck_seed_t operand;
	ck_byte_t seed_byte;
	ck_byte_t opb  [`CK_BYTES];
	ck_byte_t mix  [`CK_BYTES];
	ck_byte_t idx  [`CK_BYTES];
	ck_byte_t sub  [`CK_BYTES];
	ck_byte_t lane [`CK_BYTES];
	ck_byte_t sum_lo;
	ck_byte_t sum_hi;
	ck_byte_t init_lo;
	ck_byte_t init_hi;
	ck_word_t round_word;
	ck_word_t init_word;

	// init always takes the fresh seed.
	assign operand = (op.src == SRC_SEED || op.init) ? op.seed : chain[`CK_SEED_BYTE*8-1:0];
	assign seed_byte = operand[`CK_SEED_BYTE*8-1 -: 8];

	// lanes follow output bytes; 3 and 7 hold check sums.
	assign opb[0] = operand[7:0];
	assign opb[1] = operand[15:8];
	assign opb[2] = operand[23:16];
	assign opb[3] = 8'h00;
	assign opb[4] = operand[31:24];
	assign opb[5] = operand[39:32];
	assign opb[6] = operand[47:40];
	assign opb[7] = 8'h00;

	always_comb begin
		for (int i = 0; i < `CK_BYTES; i++) begin
			mix[i] = 8'h00;
			idx[i] = opb[i] + seed_byte;
		end
		mix[0] = op.loops[7:0];   // loop value only touches the two low lanes.
		mix[1] = op.loops[15:8];
	end

	ck_sbox u_sbox (
		.idx(idx),
		.sub(sub)
	);

	always_comb begin
		for (int i = 0; i < `CK_BYTES; i++)
			lane[i] = sub[i] ^ opb[i] ^ mix[i];
	end

	assign sum_lo = lane[0] + lane[1] + lane[2];
	assign sum_hi = lane[4] + lane[5] + lane[6];
	assign round_word = {sum_hi, lane[6], lane[5], lane[4], sum_lo, lane[2], lane[1], lane[0]};

	// init form without the table.
	assign init_lo = opb[0] + opb[1] + opb[2];
	assign init_hi = opb[4] + opb[5];
	assign init_word = {init_hi, 8'h00, opb[5], opb[4], init_lo, opb[2], opb[1], opb[0]};

	assign key.valid = op.valid;
	assign key.slot  = op.slot;
	assign key.word  = op.init ? init_word : round_word;

endmodule

`default_nettype wire

/* rtl/ck_round_result.sv */
`default_nettype none

module ck_round_result (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ck_types_pkg::ck_key_t  key,
	output ck_types_pkg::ck_word_t chain,
	output logic                   out_valid,
	output ck_types_pkg::ck_key_t  out_key,
	output ck_types_pkg::ck_word_t even_key,
	output ck_types_pkg::ck_word_t odd_key
);
	import ck_ctrl_pkg::*;

	// chain updates on the same edge the next op leaves decode,
	// so back to back chain commands see it in time.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chain     <= '0;
			even_key  <= '0;
			odd_key   <= '0;
			out_key   <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= key.valid; // one pulse per key.
			if (key.valid) begin
				chain   <= key.word;
				out_key <= key;
				if (key.slot == SLOT_ODD)
					odd_key <= key.word;
				else
					even_key <= key.word;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/ck_sbox.sv */
`include "ck_defines.svh"
`default_nettype none

module ck_sbox (
	input  ck_types_pkg::ck_byte_t idx [`CK_BYTES],
	output ck_types_pkg::ck_byte_t sub [`CK_BYTES]
);

	// entry 0 in the low byte, entry 255 on top.
	localparam logic [2047:0] sbox_table = {
		128'h22cce3bd368ade651ad93f10200b80bf,
		128'h21045432a93d9038cd1c66ad8572d8c1,
		128'hc71d9a295b4e5d7d8ddcb8f3508bf49e,
		128'h628e23fd30067e9969f85e46d4a3e0ce,
		128'hc3f50efecb2aacb08fbcebca880aa2ab,
		128'heed5ef915c9cf9afb22f61ff352dc886,
		128'h4d53bb00baa0b492ed9b977fe84a636d,
		128'he2dadff2a598b3d240c63aa770f779f6,
		128'h483c0f71688295d676091803ae316733,
		128'h7cdd4593f0d36a5857c452e573f1cf94,
		128'hd1a67841830d51db5fc9147bd00c77b9,
		128'hea1219c25517e6649f1eb1fa1bd7e459,
		128'h493728aa11c560b66c75022c4347ecbe,
		128'hfc016f1f08a405a84426e10784b56e8c,
		128'h2b2542876b7a899d4b7416a13e2413fb,
		128'he7812ec03b4f4c155627965ab734e939
	};

	// eight independent lookups.
	always_comb begin
		for (int i = 0; i < `CK_BYTES; i++) begin
			sub[i] = sbox_table[{idx[i], 3'b000} +: 8];
		end
	end

endmodule

`default_nettype wire

/* rtl/ck_types_pkg.sv */
`include "ck_defines.svh"
`default_nettype none

package ck_types_pkg;

	typedef logic [7:0]                    ck_byte_t;
	typedef logic [`CK_BYTES*8-1:0]        ck_word_t;
	typedef logic [`CK_SEED_BYTE*8-1:0]    ck_seed_t; // seed byte on top.
	typedef logic [31:0]                   ck_block_t;
	typedef logic [`CK_LOOP_W-1:0]         ck_loop_t;

	typedef struct packed {
		logic      init;
		ck_block_t block;
		ck_seed_t  seed;
		ck_loop_t  loops;
	} ck_cmd_t;

	// decoded command, header bits already turned into enums.
	typedef struct packed {
		logic                 valid;
		logic                 init;
		ck_ctrl_pkg::ck_src_e  src;
		ck_ctrl_pkg::ck_slot_e slot;
		ck_seed_t             seed;
		ck_loop_t             loops;
	} ck_op_t;

	typedef struct packed {
		logic                 valid;
		ck_ctrl_pkg::ck_slot_e slot;
		ck_word_t             word;
	} ck_key_t;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, then decide from the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f all.f --top-module ck_engine_tb -o ck_engine_sim \
	&& ./obj_dir/ck_engine_sim > sim.log 2>&1

grep -q "^TESTS PASSED$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
